/* src.f */
src/usb_xact_pkg.sv
src/token_match.sv
src/bulk_sequencer.sv
src/handshake_issuer.sv
src/in_data_path.sv
src/usb_bulk_transactor.sv
tb/usb_bulk_transactor_assert.sv
tb/tb_usb_bulk_transactor.sv

/* Makefile */
# Verilator build for the bulk transactor testbench

VERILATOR  ?= verilator
FLAGS      := --timing --assert
BUILD_OPTS := -j 0
TOP        := tb_usb_bulk_transactor
FILELIST   := src.f
BUILD_DIR  := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# A $fatal or a failed assertion gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(FLAGS) $(BUILD_OPTS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_usb_bulk_transactor.sv */
`timescale 1ns/100ps

module tb_usb_bulk_transactor import usb_xact_pkg::*; ();

  localparam int unsigned BULK_EP = 1;
  localparam logic [USB_ADDR_W-1:0] DEV_ADDR = 7'h2a;
  localparam int TIMEOUT = 100;
  // Which output wait_signal watches
  localparam int SEL_CYCLE = 0;
  localparam int SEL_HSK = 1;
  localparam int SEL_SEND = 2;

  logic clock = 1'b0;
  logic reset;
  logic tok_recv_i, hsk_recv_i, hsk_send_o, usb_send_o, usb_zero_o, blk_cycle_o;
  logic [1:0] tok_type_i, hsk_type_i, hsk_type_o, usb_type_o;
  logic [USB_ADDR_W-1:0] usb_addr_i, tok_addr_i;
  logic [USB_ENDP_W-1:0] tok_endp_i;
  logic usb_tvalid_i, usb_tready_o, usb_tlast_i, usb_tvalid_o, usb_tready_i, usb_tlast_o;
  logic blk_tvalid_o, blk_tready_i, blk_tlast_o, blk_tvalid_i, blk_tready_o, blk_tlast_i;
  logic blk_out_ready_i, blk_in_ready_i;
  logic [BYTE_W-1:0] usb_tdata_i, usb_tdata_o, blk_tdata_o, blk_tdata_i;
  // Driven by the encoder model only
  logic usb_busy_i = 1'b0;
  logic hsk_sent_i = 1'b0;
  logic send_seen;
  logic hsk_seen;
  // Expected DATA0/DATA1 toggle
  logic toggle;
  integer seed;
  // Current packet shared by the OUT and IN runs
  logic [BYTE_W-1:0] pkt [0:7];
  int len;

  usb_bulk_transactor #(.BULK_ENDPOINT(BULK_EP)) i_usb_bulk_transactor (.*);

  bind usb_bulk_transactor usb_bulk_transactor_assert i_usb_bulk_transactor_assert (
    .clock(clock), .reset(reset), .hsk_send_o(hsk_send_o), .hsk_sent_i(hsk_sent_i),
    .usb_tvalid_o(usb_tvalid_o), .usb_tready_i(usb_tready_i), .usb_tlast_o(usb_tlast_o),
    .usb_tdata_o(usb_tdata_o), .blk_tvalid_o(blk_tvalid_o), .blk_cycle_o(blk_cycle_o)
  );

  always #5 clock = ~clock;

  // Encoder model pulses busy or sent for one cycle after each request
  always begin
    @(negedge clock);
    send_seen = usb_send_o && !usb_busy_i;
    hsk_seen  = hsk_send_o && !hsk_sent_i;
    @(posedge clock);
    #1;
    usb_busy_i = send_seen;
    hsk_sent_i = hsk_seen;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic guard_step(inout int guard, input string what);
    guard = guard + 1;
    if (guard > TIMEOUT) begin
      $display("Timeout at %0t while waiting for %s", $time, what);
      stop_run();
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  // Waits for a level, and no data may move meanwhile
  task automatic wait_signal(input int sel, input logic level, input string what);
    int guard;
    logic val;
    guard = 0;
    do begin
      guard_step(guard, what);
      @(negedge clock);
      case (sel)
        SEL_CYCLE: val = blk_cycle_o;
        SEL_HSK:   val = hsk_send_o;
        default:   val = usb_send_o;
      endcase
      check_value("usb_tvalid_o", 32'(usb_tvalid_o), 0);
      check_value("blk_tvalid_o", 32'(blk_tvalid_o), 0);
      tick();
    end while (val != level);
  endtask

  task automatic make_packet();
    len = 1 + ($random(seed) & 7);
    for (int i = 0; i < 8; i++) begin
      pkt[i] = 8'($random(seed));
    end
  endtask

  task automatic send_token(input logic [1:0] typ, input logic [USB_ADDR_W-1:0] addr,
                            input logic [USB_ENDP_W-1:0] endp);
    tok_recv_i = 1'b1;
    tok_type_i = typ;
    tok_addr_i = addr;
    tok_endp_i = endp;
    tick();
    tok_recv_i = 1'b0;
  endtask

  // Host sends an OUT packet while the sink stalls at random
  task automatic run_out(input logic sink_ok);
    int idx;
    int guard;
    make_packet();
    blk_out_ready_i = sink_ok;
    send_token(TOK_OUT, DEV_ADDR, USB_ENDP_W'(BULK_EP));
    wait_signal(SEL_CYCLE, 1'b1, "OUT transfer start");
    idx = 0;
    guard = 0;
    while (idx < len) begin
      guard_step(guard, "OUT byte accept");
      usb_tvalid_i = 1'b1;
      usb_tdata_i  = pkt[idx[2:0]];
      usb_tlast_i  = idx == len - 1;
      blk_tready_i = ($random(seed) & 3) != 0;
      @(negedge clock);
      // Sink sees each byte or nothing while the packet drains
      check_value("blk_tvalid_o", 32'(blk_tvalid_o), 32'(sink_ok));
      check_value("usb_tready_o", 32'(usb_tready_o), 32'(sink_ok ? blk_tready_i : 1'b1));
      if (sink_ok) begin
        check_value("blk_tdata_o", 32'(blk_tdata_o), 32'(pkt[idx[2:0]]));
        check_value("blk_tlast_o", 32'(blk_tlast_o), 32'(idx == len - 1));
      end
      if (usb_tready_o) idx++;
      tick();
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
    wait_signal(SEL_HSK, 1'b1, "handshake request");
    check_value("hsk_type_o", 32'(hsk_type_o), 32'(sink_ok ? HSK_ACK : HSK_NAK));
    wait_signal(SEL_CYCLE, 1'b0, "OUT transfer end");
    // Only a sent ACK moves the toggle
    if (sink_ok) toggle = !toggle;
  endtask

  // Host asks for IN data and answers ACK or NAK while the encoder stalls at random
  task automatic run_in(input logic src_ok);
    int src_idx;
    int rx_idx;
    int guard;
    logic ack;
    make_packet();
    blk_in_ready_i = src_ok;
    // Source offers a byte even when it is not ready
    blk_tvalid_i = !src_ok;
    blk_tdata_i  = pkt[0];
    send_token(TOK_IN, DEV_ADDR, USB_ENDP_W'(BULK_EP));
    wait_signal(SEL_SEND, 1'b1, "IN send request");
    check_value("usb_type_o", 32'(usb_type_o), 32'(toggle ? DATA1 : DATA0));
    check_value("usb_zero_o", 32'(usb_zero_o), 32'(!src_ok));
    // Zero packet is done once the encoder goes busy
    if (!src_ok) wait_signal(SEL_SEND, 1'b0, "zero packet taken");
    src_idx = 0;
    rx_idx = 0;
    guard = 0;
    while (src_ok && rx_idx < len) begin
      guard_step(guard, "IN byte accept");
      blk_tvalid_i = src_idx < len;
      blk_tdata_i  = pkt[src_idx[2:0]];
      blk_tlast_i  = src_idx == len - 1;
      usb_tready_i = ($random(seed) & 3) != 0;
      @(negedge clock);
      if (blk_tvalid_i && blk_tready_o) src_idx++;
      if (usb_tvalid_o && usb_tready_i) begin
        check_value("usb_tdata_o", 32'(usb_tdata_o), 32'(pkt[rx_idx[2:0]]));
        check_value("usb_tlast_o", 32'(usb_tlast_o), 32'(rx_idx == len - 1));
        rx_idx++;
      end
      tick();
    end
    blk_tvalid_i = 1'b0;
    blk_tlast_i  = 1'b0;
    ack = ($random(seed) & 1) != 0;
    hsk_recv_i = 1'b1;
    hsk_type_i = ack ? HSK_ACK : HSK_NAK;
    tick();
    hsk_recv_i = 1'b0;
    wait_signal(SEL_CYCLE, 1'b0, "IN transfer end");
    if (ack) toggle = !toggle;
  endtask

  // Tokens for another device, another endpoint, SOF or SETUP
  task automatic run_ignored();
    int kind;
    logic [1:0] dir;
    kind = $random(seed) & 3;
    dir = ($random(seed) & 1) != 0 ? TOK_IN : TOK_OUT;
    case (kind)
      0: send_token(dir, DEV_ADDR ^ USB_ADDR_W'($random(seed) | 1), USB_ENDP_W'(BULK_EP));
      1: send_token(dir, DEV_ADDR, USB_ENDP_W'(BULK_EP) ^ USB_ENDP_W'($random(seed) | 1));
      2: send_token(TOK_SOF, DEV_ADDR, USB_ENDP_W'(BULK_EP));
      default: send_token(TOK_SETUP, DEV_ADDR, USB_ENDP_W'(BULK_EP));
    endcase
    repeat (20) begin
      @(negedge clock);
      check_value("blk_cycle_o", 32'(blk_cycle_o), 0);
      check_value("hsk_send_o", 32'(hsk_send_o), 0);
      check_value("usb_send_o", 32'(usb_send_o), 0);
      tick();
    end
  endtask

  initial begin
    int kind;
    seed = 32'h03ae37ad;
    toggle = 1'b0;
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    tok_recv_i = 1'b0;
    tok_type_i = TOK_SOF;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_recv_i = 1'b0;
    hsk_type_i = HSK_ACK;
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tdata_i = '0;
    usb_tready_i = 1'b0;
    blk_tready_i = 1'b0;
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    blk_tdata_i = '0;
    blk_out_ready_i = 1'b0;
    blk_in_ready_i = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_value("hsk_send_o,usb_send_o,usb_tvalid_o,blk_tvalid_o,blk_tready_o,blk_cycle_o",
                32'({hsk_send_o, usb_send_o, usb_tvalid_o, blk_tvalid_o, blk_tready_o,
                     blk_cycle_o}), 0);
    tick();
    // Each case once and then a random mix for the toggle
    run_out(1'b1);
    run_out(1'b0);
    run_in(1'b1);
    run_in(1'b0);
    run_ignored();
    for (int n = 0; n < 80; n++) begin
      kind = $random(seed) & 7;
      if (kind < 3) run_out(($random(seed) & 3) != 0);
      else if (kind < 6) run_in(($random(seed) & 3) != 0);
      else run_ignored();
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* tb/usb_bulk_transactor_assert.sv */
`timescale 1ns/100ps

module usb_bulk_transactor_assert import usb_xact_pkg::*; (
  input logic              clock,
  input logic              reset,
  input logic              hsk_send_o,
  input logic              hsk_sent_i,
  input logic              usb_tvalid_o,
  input logic              usb_tready_i,
  input logic              usb_tlast_o,
  input logic [BYTE_W-1:0] usb_tdata_o,
  input logic              blk_tvalid_o,
  input logic              blk_cycle_o
);

  // Handshake request stays up until the encoder reports it sent
  hsk_send_hold: assert property (
    @(posedge clock) disable iff (reset) hsk_send_o && !hsk_sent_i |=> hsk_send_o
  ) else $error("hsk_send_o dropped before hsk_sent_i");

  // Encoder stream keeps its byte while stalled
  usb_tvalid_hold: assert property (
    @(posedge clock) disable iff (reset)
      usb_tvalid_o && !usb_tready_i |=>
        usb_tvalid_o && $stable(usb_tdata_o) && $stable(usb_tlast_o)
  ) else $error("usb_tvalid_o, usb_tdata_o or usb_tlast_o changed while stalled");

  // Sink stream only active inside a bulk cycle
  blk_tvalid_in_cycle: assert property (
    @(posedge clock) disable iff (reset) blk_tvalid_o |-> blk_cycle_o
  ) else $error("blk_tvalid_o high outside blk_cycle_o");

endmodule

/* src/usb_bulk_transactor.sv */
`timescale 1ns/100ps

module usb_bulk_transactor import usb_xact_pkg::*; #(
  parameter int unsigned BULK_ENDPOINT = 1
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [USB_ADDR_W-1:0] usb_addr_i,
  // Decoder tokens and host handshakes
  input  logic                  tok_recv_i,
  input  logic [1:0]            tok_type_i,
  input  logic [USB_ADDR_W-1:0] tok_addr_i,
  input  logic [USB_ENDP_W-1:0] tok_endp_i,
  input  logic                  hsk_recv_i,
  input  logic [1:0]            hsk_type_i,
  // Encoder handshake and data requests
  output logic                  hsk_send_o,
  output logic [1:0]            hsk_type_o,
  input  logic                  hsk_sent_i,
  output logic                  usb_send_o,
  output logic [1:0]            usb_type_o,
  output logic                  usb_zero_o,
  input  logic                  usb_busy_i,
  // Decoder and encoder byte streams
  input  logic                  usb_tvalid_i,
  output logic                  usb_tready_o,
  input  logic                  usb_tlast_i,
  input  logic [BYTE_W-1:0]     usb_tdata_i,
  output logic                  usb_tvalid_o,
  input  logic                  usb_tready_i,
  output logic                  usb_tlast_o,
  output logic [BYTE_W-1:0]     usb_tdata_o,
  // Bulk sink and source
  output logic                  blk_tvalid_o,
  input  logic                  blk_tready_i,
  output logic                  blk_tlast_o,
  output logic [BYTE_W-1:0]     blk_tdata_o,
  input  logic                  blk_out_ready_i,
  input  logic                  blk_tvalid_i,
  output logic                  blk_tready_o,
  input  logic                  blk_tlast_i,
  input  logic [BYTE_W-1:0]     blk_tdata_i,
  input  logic                  blk_in_ready_i,
  output logic                  blk_cycle_o
);

  logic xfer_start, xfer_in, busy;
  logic hsk_req, hsk_nak;
  logic tx_load, tx_zero, tx_en, data_odd;
  logic tx_last_done, tx_zero_done;

  token_match #(.BULK_ENDPOINT(BULK_ENDPOINT)) i_token_match (
    .clock, .reset, .usb_addr_i, .tok_recv_i, .tok_type_i, .tok_addr_i, .tok_endp_i,
    .busy_i(busy), .start_o(xfer_start), .in_o(xfer_in)
  );

  bulk_sequencer i_bulk_sequencer (
    .clock, .reset, .start_i(xfer_start), .in_i(xfer_in), .blk_in_ready_i, .blk_out_ready_i,
    .usb_tvalid_i, .usb_tready_o, .usb_tlast_i, .usb_tdata_i, .hsk_recv_i, .hsk_type_i,
    .hsk_sent_i, .tx_last_done_i(tx_last_done), .tx_zero_done_i(tx_zero_done),
    .blk_tvalid_o, .blk_tready_i, .blk_tlast_o, .blk_tdata_o, .blk_cycle_o,
    .busy_o(busy), .hsk_req_o(hsk_req), .hsk_nak_o(hsk_nak), .tx_load_o(tx_load),
    .tx_zero_o(tx_zero), .tx_en_o(tx_en), .data_odd_o(data_odd)
  );

  handshake_issuer i_handshake_issuer (
    .clock, .reset, .hsk_req_i(hsk_req), .hsk_nak_i(hsk_nak), .hsk_sent_i,
    .hsk_send_o, .hsk_type_o
  );

  in_data_path i_in_data_path (
    .clock, .reset, .tx_load_i(tx_load), .tx_zero_i(tx_zero), .tx_en_i(tx_en),
    .data_odd_i(data_odd), .blk_tvalid_i, .blk_tready_o, .blk_tlast_i, .blk_tdata_i,
    .usb_tvalid_o, .usb_tready_i, .usb_tlast_o, .usb_tdata_o, .usb_send_o, .usb_type_o,
    .usb_zero_o, .usb_busy_i, .tx_last_done_o(tx_last_done), .tx_zero_done_o(tx_zero_done)
  );

endmodule

/* src/in_data_path.sv */
`timescale 1ns/100ps

module in_data_path import usb_xact_pkg::*; (
  input  logic              clock,
  input  logic              reset,

  // Controls from the sequencer
  input  logic              tx_load_i,
  input  logic              tx_zero_i,
  input  logic              tx_en_i,
  input  logic              data_odd_i,

  // Bulk source stream
  input  logic              blk_tvalid_i,
  output logic              blk_tready_o,
  input  logic              blk_tlast_i,
  input  logic [BYTE_W-1:0] blk_tdata_i,

  // Encoder stream and send request
  output logic              usb_tvalid_o,
  input  logic              usb_tready_i,
  output logic              usb_tlast_o,
  output logic [BYTE_W-1:0] usb_tdata_o,
  output logic              usb_send_o,
  output logic [1:0]        usb_type_o,
  output logic              usb_zero_o,
  input  logic              usb_busy_i,

  output logic              tx_last_done_o,
  output logic              tx_zero_done_o
);

  logic              send_q;
  logic              zero_q;
  data_pid_t         type_q;
  logic              vld_q;
  logic              last_q;
  logic [BYTE_W-1:0] data_q;
  logic              got_last_q;
  logic              take;

  // Send request held until the encoder goes busy
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (send_q) begin
      if (usb_busy_i) begin
        send_q <= 1'b0;
      end
    end else if (tx_load_i) begin
      send_q <= 1'b1;
    end
  end

  // Packet type and zero flag, fixed for the whole packet
  always_ff @(posedge clock) begin
    if (tx_load_i && !send_q) begin
      zero_q <= tx_zero_i;
      type_q <= data_odd_i ? DATA1 : DATA0;
    end
  end

  // Stage refills when empty or draining, and stops after the last byte
  assign blk_tready_o = tx_en_i && !got_last_q && (!vld_q || usb_tready_i);
  assign take         = blk_tvalid_i && blk_tready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      vld_q <= 1'b0;
    end else if (take) begin
      vld_q <= 1'b1;
    end else if (usb_tready_i) begin
      vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      data_q <= blk_tdata_i;
      last_q <= blk_tlast_i;
    end
  end

  // Blocks the next packet's bytes until the transfer ends
  always_ff @(posedge clock) begin
    if (reset || !tx_en_i) begin
      got_last_q <= 1'b0;
    end else if (take && blk_tlast_i) begin
      got_last_q <= 1'b1;
    end
  end

  assign usb_tvalid_o = vld_q;
  assign usb_tlast_o  = last_q;
  assign usb_tdata_o  = data_q;
  assign usb_send_o   = send_q;
  assign usb_type_o   = type_q;
  assign usb_zero_o   = zero_q;

  assign tx_last_done_o = vld_q && usb_tready_i && last_q;
  assign tx_zero_done_o = send_q && zero_q && usb_busy_i;

endmodule

/* src/handshake_issuer.sv */
`timescale 1ns/100ps

module handshake_issuer import usb_xact_pkg::*; (
  input  logic       clock,
  input  logic       reset,

  // Request from the sequencer
  input  logic       hsk_req_i,
  input  logic       hsk_nak_i,

  // Encoder side
  input  logic       hsk_sent_i,
  output logic       hsk_send_o,
  output logic [1:0] hsk_type_o
);

  logic      send_q;
  hsk_type_t type_q;
  logic      accept;

  // New requests are taken only while nothing is held
  assign accept = hsk_req_i && !send_q;

  // Send request, dropped the cycle after the sent pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (send_q) begin
      if (hsk_sent_i) begin
        send_q <= 1'b0;
      end
    end else if (hsk_req_i) begin
      send_q <= 1'b1;
    end
  end

  // Handshake code, captured with the request
  always_ff @(posedge clock) begin
    if (accept) begin
      type_q <= hsk_nak_i ? HSK_NAK : HSK_ACK;
    end
  end

  assign hsk_send_o = send_q;
  assign hsk_type_o = type_q;

endmodule

/* src/bulk_sequencer.sv */
`timescale 1ns/100ps

module bulk_sequencer import usb_xact_pkg::*; (
  input  logic              clock,
  input  logic              reset,

  // Transfer start from the token matcher
  input  logic              start_i,
  input  logic              in_i,

  // Endpoint buffer status
  input  logic              blk_in_ready_i,
  input  logic              blk_out_ready_i,

  // Received stream from the decoder
  input  logic              usb_tvalid_i,
  output logic              usb_tready_o,
  input  logic              usb_tlast_i,
  input  logic [BYTE_W-1:0] usb_tdata_i,

  // Handshakes from the host and to the encoder
  input  logic              hsk_recv_i,
  input  logic [1:0]        hsk_type_i,
  input  logic              hsk_sent_i,

  // Completion flags from the IN data path
  input  logic              tx_last_done_i,
  input  logic              tx_zero_done_i,

  // Bulk sink stream
  output logic              blk_tvalid_o,
  input  logic              blk_tready_i,
  output logic              blk_tlast_o,
  output logic [BYTE_W-1:0] blk_tdata_o,

  output logic              blk_cycle_o,
  output logic              busy_o,
  output logic              hsk_req_o,
  output logic              hsk_nak_o,
  output logic              tx_load_o,
  output logic              tx_zero_o,
  output logic              tx_en_o,
  output logic              data_odd_o
);

  blk_state_t state;
  logic       odd_q;
  logic       nak_q;
  logic       load_q;
  logic       rx_last;

  // Last byte of the OUT packet leaves the decoder
  assign rx_last = usb_tvalid_i && usb_tready_o && usb_tlast_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= BLK_IDLE;
    end else begin
      case (state)
        BLK_IDLE: begin
          // Pick the data or fallback path from the buffer status
          if (start_i && in_i) begin
            state <= blk_in_ready_i ? BLK_DATI_TX : BLK_DATI_ZDP;
          end else if (start_i) begin
            state <= blk_out_ready_i ? BLK_DATO_RX : BLK_DATO_ERR;
          end
        end
        // IN data runs until the encoder takes the last byte
        BLK_DATI_TX: if (tx_last_done_i) state <= BLK_DATI_ACK;
        BLK_DATI_ZDP: if (tx_zero_done_i) state <= BLK_DATI_ACK;
        // Any host handshake closes the IN transfer
        BLK_DATI_ACK: if (hsk_recv_i) state <= BLK_DONE;
        // OUT packet, forwarded or drained
        BLK_DATO_RX, BLK_DATO_ERR: if (rx_last) state <= BLK_DATO_HSK;
        BLK_DATO_HSK: if (hsk_sent_i) state <= BLK_DONE;
        default: state <= BLK_IDLE;
      endcase
    end
  end

  // NAK is chosen at start, when the sink has no room
  always_ff @(posedge clock) begin
    if (reset) begin
      nak_q <= 1'b0;
    end else if (state == BLK_IDLE && start_i) begin
      nak_q <= !blk_out_ready_i;
    end
  end

  // Marks the first cycle of an IN transfer
  always_ff @(posedge clock) begin
    if (reset) begin
      load_q <= 1'b0;
    end else begin
      load_q <= state == BLK_IDLE && start_i && in_i;
    end
  end

  // DATA0/DATA1 toggle
  always_ff @(posedge clock) begin
    if (reset) begin
      odd_q <= 1'b0;
    end else if (state == BLK_DATI_ACK && hsk_recv_i && hsk_type_i == HSK_ACK) begin
      odd_q <= !odd_q;
    end else if (state == BLK_DATO_HSK && hsk_sent_i && !nak_q) begin
      odd_q <= !odd_q;
    end
  end

  // Sink sees bytes only in RX; ERR and idle states drain the decoder
  assign blk_tvalid_o = state == BLK_DATO_RX && usb_tvalid_i;
  assign blk_tlast_o  = usb_tlast_i;
  assign blk_tdata_o  = usb_tdata_i;
  assign usb_tready_o = state == BLK_DATO_RX ? blk_tready_i : 1'b1;

  // Cycle ends as DONE is entered, busy one cycle later
  assign blk_cycle_o = state != BLK_IDLE && state != BLK_DONE;
  assign busy_o      = state != BLK_IDLE;

  // Handshake request, held for the whole HSK state
  assign hsk_req_o = state == BLK_DATO_HSK;
  assign hsk_nak_o = nak_q;

  // IN side controls
  assign tx_load_o  = load_q;
  assign tx_zero_o  = state == BLK_DATI_ZDP;
  assign tx_en_o    = state == BLK_DATI_TX;
  assign data_odd_o = odd_q;

endmodule

/* src/token_match.sv */
`timescale 1ns/100ps

module token_match import usb_xact_pkg::*; #(
  parameter int unsigned BULK_ENDPOINT = 1
) (
  input  logic                  clock,
  input  logic                  reset,

  // Address assigned to this device
  input  logic [USB_ADDR_W-1:0] usb_addr_i,

  // Decoded token, valid while tok_recv_i is high
  input  logic                  tok_recv_i,
  input  logic [1:0]            tok_type_i,
  input  logic [USB_ADDR_W-1:0] tok_addr_i,
  input  logic [USB_ENDP_W-1:0] tok_endp_i,

  // Sequencer is running a transfer
  input  logic                  busy_i,

  output logic                  start_o,
  output logic                  in_o
);

  logic addr_hit;
  logic endp_hit;
  logic type_hit;
  logic match;
  logic start_q;
  logic in_q;

  // Only IN and OUT tokens on the bulk endpoint start a transfer
  assign addr_hit = tok_addr_i == usb_addr_i;
  assign endp_hit = tok_endp_i == USB_ENDP_W'(BULK_ENDPOINT);
  assign type_hit = tok_type_i == TOK_IN || tok_type_i == TOK_OUT;

  // A pending start counts as busy, so back-to-back tokens give one start
  assign match = tok_recv_i && addr_hit && endp_hit && type_hit && !busy_i && !start_q;

  // One-cycle start pulse, one cycle after the token
  always_ff @(posedge clock) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= match;
    end
  end

  // Direction of the matched token, held until the next match
  always_ff @(posedge clock) begin
    if (match) begin
      in_q <= tok_type_i == TOK_IN;
    end
  end

  assign start_o = start_q;
  assign in_o    = in_q;

endmodule

/* src/usb_xact_pkg.sv */
package usb_xact_pkg;

  // Field widths of the token and data packets
  localparam int USB_ADDR_W = 7;
  localparam int USB_ENDP_W = 4;
  localparam int BYTE_W     = 8;

  // Token codes, as the decoder reports them
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake codes, shared by the decoder and the encoder
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_t;

  // Data packet types, selected by the toggle bit
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_t;

  // Bulk transfer sequencer states
  typedef enum logic [2:0] {
    BLK_IDLE, BLK_DATI_TX, BLK_DATI_ZDP, BLK_DATI_ACK,
    BLK_DATO_RX, BLK_DATO_ERR, BLK_DATO_HSK, BLK_DONE
  } blk_state_t;

endpackage
